// File: lc_pkg.sv
`default_nettype none

package lc_pkg;

    // Machine sizes
    localparam int word_width = 16;
    localparam int addr_width = 8;
    localparam int mem_depth  = 256;

    // Serial bit time in sysclk cycles
    localparam int clks_per_bit = 16;

    // Core step period while free-running
    localparam int run_div = 4;

    // Opcodes of the reduced LC-3 set, anything else is a no-op
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ld   = 4'b0010,
        op_st   = 4'b0011,
        op_and  = 4'b0101,
        op_not  = 4'b1001,
        op_halt = 4'b1111
    } opcode_t;

    // Multicycle core sequence
    typedef enum logic [1:0] {
        st_fetch,
        st_exec,
        st_mem,
        st_halt
    } core_state_t;

endpackage

`default_nettype wire

// File: uart_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module uart_receiver (
    input  wire logic       sysclk,
    input  wire logic       sysrst,
    input  wire logic       rxd,
    output logic            byte_valid,
    output logic [7:0]      byte_data
);
    import lc_pkg::*;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t                          state;
    logic [$clog2(clks_per_bit)-1:0]    bit_cnt;
    logic [2:0]                         bit_idx;
    logic                               rx_meta;
    logic                               rx_sync;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            state      <= rx_idle;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            rx_meta    <= 1'b1;
            rx_sync    <= 1'b1;
            byte_valid <= 1'b0;
        end else begin
            rx_meta    <= rxd;
            rx_sync    <= rx_meta;
            byte_valid <= 1'b0;
            bit_cnt    <= bit_cnt + 1'b1;
            case (state)
                rx_idle: begin
                    bit_cnt <= '0;
                    if (!rx_sync) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    // Centre of start bit, a high line here was only a glitch
                    if (bit_cnt == clks_per_bit / 2 - 1) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? rx_idle : rx_data;
                    end
                end
                rx_data: begin
                    if (bit_cnt == clks_per_bit - 1) begin
                        // LSB arrives first, so shift in from the top
                        byte_data <= {rx_sync, byte_data[7:1]};
                        bit_cnt   <= '0;
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end
                    end
                end
                default: begin
                    if (bit_cnt == clks_per_bit - 1) begin
                        byte_valid <= rx_sync;
                        state      <= rx_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: uart_loader.sv
`timescale 1ns/1ps
`default_nettype none

module uart_loader (
    input  wire logic                           sysclk,
    input  wire logic                           sysrst,
    input  wire logic                           load_en,
    input  wire logic                           byte_valid,
    input  wire logic [7:0]                     byte_data,
    output logic                                load_we,
    output logic [lc_pkg::addr_width-1:0]       load_addr,
    output logic [lc_pkg::word_width-1:0]       load_data
);

    logic [7:0] hi_byte;
    logic       phase;
    logic       load_en_q;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            phase     <= 1'b0;
            load_en_q <= 1'b0;
            load_we   <= 1'b0;
            load_addr <= '0;
        end else begin
            load_en_q <= load_en;
            load_we   <= byte_valid && load_en && phase;
            if (load_we) begin
                load_addr <= load_addr + 1'b1;
            end
            if (byte_valid && load_en) begin
                phase <= !phase;
                if (phase) begin
                    load_data <= {hi_byte, byte_data};
                end else begin
                    hi_byte <= byte_data;
                end
            end
            // New load session starts over at word 0
            if (load_en && !load_en_q) begin
                phase     <= 1'b0;
                load_addr <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: step_control.sv
`timescale 1ns/1ps
`default_nettype none

module step_control (
    input  wire logic   sysclk,
    input  wire logic   sysrst,
    input  wire logic   run_en,
    input  wire logic   step_key,
    output logic        step_en
);
    import lc_pkg::*;

    logic [$clog2(run_div)-1:0] div_cnt;
    logic                       key_meta;
    logic                       key_sync;
    logic                       key_q;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            div_cnt  <= '0;
            key_meta <= 1'b0;
            key_sync <= 1'b0;
            key_q    <= 1'b0;
            step_en  <= 1'b0;
        end else begin
            key_meta <= step_key;
            key_sync <= key_meta;
            key_q    <= key_sync;
            // Divider restarts whenever run mode is left
            div_cnt  <= run_en ? div_cnt + 1'b1 : '0;
            if (run_en) begin
                step_en <= (div_cnt == run_div - 1);
            end else begin
                step_en <= key_sync && !key_q;
            end
        end
    end

endmodule

`default_nettype wire

// File: lc_memory.sv
`timescale 1ns/1ps
`default_nettype none

module lc_memory (
    input  wire logic                           sysclk,
    input  wire logic                           load_we,
    input  wire logic [lc_pkg::addr_width-1:0]  load_addr,
    input  wire logic [lc_pkg::word_width-1:0]  load_data,
    input  wire logic [lc_pkg::addr_width-1:0]  pc,
    output logic      [lc_pkg::word_width-1:0]  instr,
    input  wire logic [lc_pkg::addr_width-1:0]  data_addr,
    input  wire logic [lc_pkg::word_width-1:0]  data_wdata,
    input  wire logic                           data_we,
    output logic      [lc_pkg::word_width-1:0]  data_rdata
);
    import lc_pkg::*;

    logic [word_width-1:0] mem [mem_depth];

    // Loader has priority, the core is held during a load anyway
    always_ff @(posedge sysclk) begin
        if (load_we) begin
            mem[load_addr] <= load_data;
        end else if (data_we) begin
            mem[data_addr] <= data_wdata;
        end
    end

    assign instr      = mem[pc];
    assign data_rdata = mem[data_addr];

endmodule

`default_nettype wire

// File: lc_core.sv
`timescale 1ns/1ps
`default_nettype none

module lc_core (
    input  wire logic                           sysclk,
    input  wire logic                           sysrst,
    input  wire logic                           hold,
    input  wire logic                           step_en,
    input  wire logic [lc_pkg::word_width-1:0]  instr,
    input  wire logic [lc_pkg::word_width-1:0]  data_rdata,
    output logic      [lc_pkg::addr_width-1:0]  pc,
    output logic      [lc_pkg::addr_width-1:0]  data_addr,
    output logic      [lc_pkg::word_width-1:0]  data_wdata,
    output logic                                data_we,
    output logic      [lc_pkg::word_width-1:0]  r0,
    output logic                                halted
);
    import lc_pkg::*;

    core_state_t            state;
    logic [word_width-1:0]  regs [8];
    logic [word_width-1:0]  ir;
    logic [2:0]             nzp;

    opcode_t                op;
    logic [2:0]             dr;
    logic [word_width-1:0]  src_a;
    logic [word_width-1:0]  src_b;
    logic [word_width-1:0]  imm5;
    logic [word_width-1:0]  off9;
    logic [word_width-1:0]  alu_out;

    // Condition codes from a result, as {n, z, p}
    function automatic logic [2:0] cc_of(input logic [word_width-1:0] value);
        if (value[word_width-1]) begin
            return 3'b100;
        end else if (value == '0) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    // Field decode
    assign op    = opcode_t'(ir[15:12]);
    assign dr    = ir[11:9];
    assign src_a = regs[ir[8:6]];
    assign imm5  = {{(word_width - 5){ir[4]}}, ir[4:0]};
    assign off9  = {{(word_width - 9){ir[8]}}, ir[8:0]};
    assign src_b = ir[5] ? imm5 : regs[ir[2:0]];

    always_comb begin
        case (op)
            op_add:  alu_out = src_a + src_b;
            op_and:  alu_out = src_a & src_b;
            op_not:  alu_out = ~src_a;
            default: alu_out = '0;
        endcase
    end

    // PC has already moved past the instruction when this is used
    assign data_addr  = pc + off9[addr_width-1:0];
    assign data_wdata = regs[dr];
    assign data_we    = (state == st_mem) && (op == op_st) && step_en;
    assign r0         = regs[0];

    always_ff @(posedge sysclk) begin
        if (!sysrst || hold) begin
            state  <= st_fetch;
            pc     <= '0;
            nzp    <= 3'b010;
            halted <= 1'b0;
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (step_en) begin
            case (state)
                st_fetch: begin
                    ir    <= instr;
                    pc    <= pc + 1'b1;
                    state <= st_exec;
                end
                st_exec: begin
                    state <= st_fetch;
                    case (op)
                        op_add, op_and, op_not: begin
                            regs[dr] <= alu_out;
                            nzp      <= cc_of(alu_out);
                        end
                        op_br: begin
                            if ((dr & nzp) != 3'b000) begin
                                pc <= data_addr;
                            end
                        end
                        op_ld, op_st: begin
                            state <= st_mem;
                        end
                        op_halt: begin
                            halted <= 1'b1;
                            state  <= st_halt;
                        end
                        default: ;
                    endcase
                end
                st_mem: begin
                    // Store is done by data_we, only loads write back here
                    if (op == op_ld) begin
                        regs[dr] <= data_rdata;
                        nzp      <= cc_of(data_rdata);
                    end
                    state <= st_fetch;
                end
                default: begin
                    state <= st_halt;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: seg_display.sv
`timescale 1ns/1ps
`default_nettype none

module seg_display (
    input  wire logic [23:0]    value,
    output logic      [7:0]     hex0,
    output logic      [7:0]     hex1,
    output logic      [7:0]     hex2,
    output logic      [7:0]     hex3,
    output logic      [7:0]     hex4,
    output logic      [7:0]     hex5
);

    // Active low, bit 0 is segment a through bit 6 for segment g
    function automatic logic [6:0] seg_of(input logic [3:0] nib);
        case (nib)
            4'h0:    return 7'b1000000;
            4'h1:    return 7'b1111001;
            4'h2:    return 7'b0100100;
            4'h3:    return 7'b0110000;
            4'h4:    return 7'b0011001;
            4'h5:    return 7'b0010010;
            4'h6:    return 7'b0000010;
            4'h7:    return 7'b1111000;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0010000;
            4'ha:    return 7'b0001000;
            4'hb:    return 7'b0000011;
            4'hc:    return 7'b1000110;
            4'hd:    return 7'b0100001;
            4'he:    return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    // Decimal points stay dark
    assign hex0 = {1'b1, seg_of(value[3:0])};
    assign hex1 = {1'b1, seg_of(value[7:4])};
    assign hex2 = {1'b1, seg_of(value[11:8])};
    assign hex3 = {1'b1, seg_of(value[15:12])};
    assign hex4 = {1'b1, seg_of(value[19:16])};
    assign hex5 = {1'b1, seg_of(value[23:20])};

endmodule

`default_nettype wire

// File: little_computer_top.sv
`timescale 1ns/1ps
`default_nettype none

module little_computer_top (
    input  wire logic           sysclk,
    input  wire logic           sysrst,
    input  wire logic           uart_rxd,
    input  wire logic           load_en,
    input  wire logic           run_en,
    input  wire logic           step_key,
    output logic      [7:0]     hex0,
    output logic      [7:0]     hex1,
    output logic      [7:0]     hex2,
    output logic      [7:0]     hex3,
    output logic      [7:0]     hex4,
    output logic      [7:0]     hex5,
    output logic                halted
);
    import lc_pkg::*;

    logic                   byte_valid;
    logic [7:0]             byte_data;
    logic                   load_we;
    logic [addr_width-1:0]  load_addr;
    logic [word_width-1:0]  load_data;
    logic                   step_en;
    logic [addr_width-1:0]  pc;
    logic [word_width-1:0]  instr;
    logic [addr_width-1:0]  data_addr;
    logic [word_width-1:0]  data_wdata;
    logic                   data_we;
    logic [word_width-1:0]  data_rdata;
    logic [word_width-1:0]  r0;

    uart_receiver rx_i (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .rxd        (uart_rxd),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    uart_loader loader_i (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .load_en    (load_en),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

    step_control step_i (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .run_en     (run_en),
        .step_key   (step_key),
        .step_en    (step_en)
    );

    lc_memory mem_i (
        .sysclk     (sysclk),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .pc         (pc),
        .instr      (instr),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we),
        .data_rdata (data_rdata)
    );

    // Loading holds the core in its reset state
    lc_core core_i (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .hold       (load_en),
        .step_en    (step_en),
        .instr      (instr),
        .data_rdata (data_rdata),
        .pc         (pc),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we),
        .r0         (r0),
        .halted     (halted)
    );

    seg_display disp_i (
        .value (({r0, pc})),
        .hex0  (hex0),
        .hex1  (hex1),
        .hex2  (hex2),
        .hex3  (hex3),
        .hex4  (hex4),
        .hex5  (hex5)
    );

endmodule

`default_nettype wire

// File: tb_little_computer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_little_computer;

    localparam int bit_clks = 16;
    // Six 16-word loads of about 5200 cycles each plus 300-step runs and some margin
    localparam int timeout_cycles = 100000;

    // Opcode fields as the ISA defines them
    localparam logic [3:0] add_op  = 4'b0001;
    localparam logic [3:0] and_op  = 4'b0101;
    localparam logic [3:0] not_op  = 4'b1001;
    localparam logic [3:0] ld_op   = 4'b0010;
    localparam logic [3:0] st_op   = 4'b0011;
    localparam logic [3:0] br_op   = 4'b0000;
    localparam logic [15:0] halt_word = 16'hf000;

    logic        sysclk;
    logic        sysrst;
    logic        uart_rxd;
    logic        load_en;
    logic        run_en;
    logic        step_key;
    logic [7:0]  hex0;
    logic [7:0]  hex1;
    logic [7:0]  hex2;
    logic [7:0]  hex3;
    logic [7:0]  hex4;
    logic [7:0]  hex5;
    logic        halted;

    logic [15:0] prog [16];
    int          prog_len;
    int          cycles = 0;

    little_computer_top dut_i (
        .sysclk   (sysclk),
        .sysrst   (sysrst),
        .uart_rxd (uart_rxd),
        .load_en  (load_en),
        .run_en   (run_en),
        .step_key (step_key),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3),
        .hex4     (hex4),
        .hex5     (hex5),
        .halted   (halted)
    );

    always #4 sysclk = ~sysclk;

    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    end

    task automatic tick();
        @(posedge sysclk);
        #1;
    endtask

    task automatic check_value(input string test, input logic [23:0] expected,
                               input logic [23:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s expected %h actual %h", test, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("ERROR %s", what);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    // Active-low a..g in bits 0..6
    // Decimal point must be dark
    function automatic logic [3:0] nibble_of(input logic [7:0] seg);
        case (seg)
            8'hc0:   return 4'h0;
            8'hf9:   return 4'h1;
            8'ha4:   return 4'h2;
            8'hb0:   return 4'h3;
            8'h99:   return 4'h4;
            8'h92:   return 4'h5;
            8'h82:   return 4'h6;
            8'hf8:   return 4'h7;
            8'h80:   return 4'h8;
            8'h90:   return 4'h9;
            8'h88:   return 4'ha;
            8'h83:   return 4'hb;
            8'hc6:   return 4'hc;
            8'ha1:   return 4'hd;
            8'h86:   return 4'he;
            8'h8e:   return 4'hf;
            default: return 4'hx;
        endcase
    endfunction

    // Shown as {r0, pc}
    function automatic logic [23:0] display_value();
        return {nibble_of(hex5), nibble_of(hex4), nibble_of(hex3),
                nibble_of(hex2), nibble_of(hex1), nibble_of(hex0)};
    endfunction

    function automatic logic [15:0] alu_word(input logic [3:0] op, input int dr, input int sr1,
                                             input logic imm, input int low5);
        return {op, dr[2:0], sr1[2:0], imm, low5[4:0]};
    endfunction

    function automatic logic [15:0] off_word(input logic [3:0] op, input int r, input int off);
        return {op, r[2:0], off[8:0]};
    endfunction

    // 8N1 frame with the LSB first
    task automatic send_byte(input logic [7:0] data);
        uart_rxd = 1'b0;
        repeat (bit_clks) tick();
        for (int i = 0; i < 8; i++) begin
            uart_rxd = data[i];
            repeat (bit_clks) tick();
        end
        uart_rxd = 1'b1;
        repeat (bit_clks) tick();
    endtask

    task automatic load_program(input string test);
        tick();
        run_en  = 1'b0;
        load_en = 1'b1;
        tick();
        tick();
        check_true(!halted, {test, ": halted stayed high after load started"});
        for (int i = 0; i < prog_len; i++) begin
            send_byte(prog[i][15:8]);
            send_byte(prog[i][7:0]);
        end
        repeat (2 * bit_clks) tick();
        load_en = 1'b0;
        tick();
    endtask

    task automatic press_step_key();
        step_key = 1'b1;
        repeat (8) tick();
        step_key = 1'b0;
        repeat (8) tick();
    endtask

    // Instruction-level ISA model that stops at HALT or after max_instr
    task automatic run_model(input int max_instr, output logic [15:0] exp_r0,
                             output logic [7:0] exp_pc);
        logic [15:0] m [256];
        logic [15:0] r [8];
        logic [15:0] ir;
        logic [15:0] operand;
        logic [15:0] result;
        logic [2:0]  cc;
        logic [7:0]  p;
        logic [7:0]  ea;
        logic        done;
        int          count;
        for (int i = 0; i < 256; i++) begin
            m[i] = 16'h0000;
        end
        for (int i = 0; i < prog_len; i++) begin
            m[i] = prog[i];
        end
        for (int i = 0; i < 8; i++) begin
            r[i] = 16'h0000;
        end
        cc    = 3'b010;
        p     = 8'h00;
        done  = 1'b0;
        count = 0;
        while (!done && count < max_instr) begin
            ir      = m[p];
            p       = p + 8'd1;
            count++;
            // Offset is relative to the incremented PC and wraps to 8 bits
            ea      = p + ir[7:0];
            operand = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
            result  = 16'h0000;
            case (ir[15:12])
                add_op:  result = r[ir[8:6]] + operand;
                and_op:  result = r[ir[8:6]] & operand;
                not_op:  result = ~r[ir[8:6]];
                ld_op:   result = m[ea];
                default: result = 16'h0000;
            endcase
            case (ir[15:12])
                add_op, and_op, not_op, ld_op: begin
                    r[ir[11:9]] = result;
                    cc = result[15] ? 3'b100 : ((result == 16'h0000) ? 3'b010 : 3'b001);
                end
                st_op: begin
                    m[ea] = r[ir[11:9]];
                end
                br_op: begin
                    if ((ir[11:9] & cc) != 3'b000) begin
                        p = ea;
                    end
                end
                4'b1111: begin
                    done = 1'b1;
                end
                default: ;
            endcase
        end
        exp_r0 = r[0];
        exp_pc = p;
    endtask

    task automatic run_and_check(input string test);
        logic [15:0] exp_r0;
        logic [7:0]  exp_pc;
        run_model(300, exp_r0, exp_pc);
        run_en = 1'b1;
        while (!halted) begin
            tick();
        end
        run_en = 1'b0;
        check_value(test, {exp_r0, exp_pc}, display_value());
    endtask

    task automatic reset_state();
        check_true(!halted, "reset_state: halted is high after reset");
        check_value("reset_state", 24'h000000, display_value());
    endtask

    task automatic alu_program();
        prog[0]  = alu_word(add_op, 1, 1, 1'b1, 5);
        prog[1]  = alu_word(add_op, 2, 1, 1'b1, -3);
        prog[2]  = alu_word(add_op, 0, 1, 1'b0, 2);
        prog[3]  = alu_word(and_op, 0, 0, 1'b1, 6);
        prog[4]  = alu_word(not_op, 0, 0, 1'b1, 31);
        prog[5]  = halt_word;
        prog_len = 6;
        load_program("alu_program");
        run_and_check("alu_program");
    endtask

    task automatic load_store();
        prog[0]  = alu_word(add_op, 3, 3, 1'b1, 11);
        prog[1]  = alu_word(add_op, 3, 3, 1'b0, 3);
        prog[2]  = off_word(st_op, 3, 4);
        prog[3]  = alu_word(and_op, 0, 0, 1'b1, 0);
        prog[4]  = off_word(ld_op, 0, 2);
        prog[5]  = halt_word;
        prog[6]  = 16'h0000;
        // Data word at address 7
        prog[7]  = 16'h0000;
        prog_len = 8;
        load_program("load_store");
        run_and_check("load_store");
        check_value("load_store", 24'h001606, display_value());
    endtask

    task automatic branch_loop();
        int count;
        for (int run = 0; run < 2; run++) begin
            count    = $urandom % 15 + 1;
            prog[0]  = alu_word(and_op, 0, 0, 1'b1, 0);
            prog[1]  = alu_word(and_op, 1, 1, 1'b1, 0);
            prog[2]  = alu_word(add_op, 1, 1, 1'b1, count);
            prog[3]  = alu_word(add_op, 0, 0, 1'b0, 1);
            prog[4]  = alu_word(add_op, 1, 1, 1'b1, -1);
            prog[5]  = off_word(br_op, 3'b001, -3);
            prog[6]  = halt_word;
            prog_len = 7;
            load_program("branch_loop");
            run_and_check("branch_loop");
        end
    endtask

    task automatic single_step();
        logic [15:0] exp_r0;
        logic [7:0]  exp_pc;
        prog[0]  = alu_word(add_op, 0, 0, 1'b1, 9);
        prog[1]  = halt_word;
        prog_len = 2;
        load_program("single_step");
        press_step_key();
        check_value("single_step", 24'h000001, display_value());
        press_step_key();
        run_model(1, exp_r0, exp_pc);
        check_value("single_step", {exp_r0, exp_pc}, display_value());
    endtask

    task automatic reload();
        run_and_check("reload");
        prog[0]  = alu_word(add_op, 0, 0, 1'b1, -7);
        prog[1]  = alu_word(add_op, 0, 0, 1'b0, 0);
        prog[2]  = halt_word;
        prog_len = 3;
        load_program("reload");
        run_and_check("reload");
    endtask

    initial begin
        void'($urandom(46));
        sysclk   = 1'b0;
        sysrst   = 1'b0;
        uart_rxd = 1'b1;
        load_en  = 1'b0;
        run_en   = 1'b0;
        step_key = 1'b0;
        repeat (4) tick();
        sysrst = 1'b1;
        tick();
        reset_state();
        alu_program();
        load_store();
        branch_loop();
        single_step();
        reload();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
lc_pkg.sv
uart_receiver.sv
uart_loader.sv
step_control.sv
lc_memory.sv
lc_core.sv
seg_display.sv
little_computer_top.sv
tb_little_computer.sv
